/* common/busPkg.sv */
package busPkg;

   // data memory depth in words
   localparam int MEM_ADDR_BITS = 8;
   localparam int MEM_WORDS = 1 << MEM_ADDR_BITS;

   // lane mask, bit 3 is the most significant byte
   typedef logic [3:0] byteSel_t;

   // word address into the data memory
   typedef logic [MEM_ADDR_BITS-1:0] memAddr_t;

   // access size, same as the low two opcode bits
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } accSize_t;

   // load/store operation from the core
   typedef struct packed {
      logic        valid;
      logic        store;
      accSize_t    size;
      logic [31:0] addr;
   } memOp_t;

   // request shape shared by both bus masters
   typedef struct packed {
      logic           valid;
      logic           write;
      byteSel_t       byteSel;
      memAddr_t       addr;
      regfPkg::word_t wdata;
   } busReq_t;

   // external debug access
   typedef struct packed {
      logic           valid;
      logic           write;
      memAddr_t       addr;
      regfPkg::word_t wdata;
   } dbgReq_t;

endpackage

/* common/regfPkg.sv */
package regfPkg;

   // register file geometry
   localparam int REG_COUNT = 32;

   // one data word, used across the whole datapath
   typedef logic [31:0] word_t;

   // register index
   typedef logic [4:0] regAddr_t;

   // link address, word aligned, bits 31 down to 2
   typedef logic [31:2] pcLink_t;

   // writeback source, encoding follows the decode stage
   typedef enum logic [1:0] {
      WB_RESULT = 2'd0,
      WB_LINK   = 2'd1,
      WB_LOAD   = 2'd2,
      WB_NONE   = 2'd3
   } wbSrc_t;

   // writeback control from decode
   typedef struct packed {
      regAddr_t wbAddr;
      wbSrc_t   wbSrc;
   } wbCtl_t;

endpackage

/* coreDatapath.f */
common/regfPkg.sv
common/busPkg.sv
regf/regBank.sv
regf/regFile.sv
verilog/lsuPort.sv
verilog/debugPort.sv
verilog/memArbiter.sv
verilog/dataMem.sv
verilog/coreDatapath.sv
tests/coreDatapath_tb.sv

/* regf/regBank.sv */
module regBank (
   input  logic              gclk,
   input  logic              reset,
   input  logic              readEn,
   input  regfPkg::regAddr_t readAddr,
   input  logic              writeEn,
   input  regfPkg::regAddr_t writeAddr,
   input  regfPkg::word_t    writeData,
   output regfPkg::word_t    readData
);
   import regfPkg::*;

   word_t    regs [REG_COUNT];
   regAddr_t addrQ;

   // address is captured on decode, data follows from the array
   always_ff @(posedge gclk) begin
      if (reset) begin
         addrQ <= '0;
      end else if (readEn) begin
         addrQ <= readAddr;
      end
   end

   // R0 is cleared while reset is held
   always_ff @(posedge gclk) begin
      if (reset) begin
         regs[0] <= '0;
      end else if (writeEn) begin
         regs[writeAddr] <= writeData;
      end
   end

   assign readData = regs[addrQ];

endmodule

/* regf/regFile.sv */
module regFile (
   input  logic              gclk,
   input  logic              reset,
   input  logic              exEn,
   input  logic              decEn,
   input  regfPkg::regAddr_t rdA,
   input  regfPkg::regAddr_t rdB,
   input  regfPkg::regAddr_t rdD,
   input  regfPkg::wbCtl_t   wbCtl,
   input  regfPkg::word_t    result,
   input  regfPkg::pcLink_t  pcLink,
   input  busPkg::byteSel_t  dwbSel,
   input  regfPkg::word_t    dataIn,
   input  busPkg::accSize_t  accSize,
   output regfPkg::word_t    regA,
   output regfPkg::word_t    regB,
   output regfPkg::word_t    storeData
);
   import regfPkg::*;
   import busPkg::*;

   logic     wEn;
   logic     doWrite;
   word_t    wrData;
   word_t    bankA, bankB, bankD;
   word_t    regD;
   regAddr_t rdSel, regDAddr;
   word_t    loadSized, loadData;
   logic     fwdHit;
   word_t    storeSrc;

   // writes land one cycle behind the execute enable
   assign doWrite = wEn && (wbCtl.wbSrc != WB_NONE) && (wbCtl.wbAddr != '0);

   always_comb begin
      case (wbCtl.wbSrc)
         WB_RESULT: wrData = result;
         WB_LINK:   wrData = {pcLink, 2'b00};
         WB_LOAD:   wrData = loadData;
         default:   wrData = '0;
      endcase
   end

   regBank bankAI (.gclk(gclk), .reset(reset), .readEn(decEn), .readAddr(rdA),
      .writeEn(doWrite), .writeAddr(wbCtl.wbAddr), .writeData(wrData), .readData(bankA));
   regBank bankBI (.gclk(gclk), .reset(reset), .readEn(decEn), .readAddr(rdB),
      .writeEn(doWrite), .writeAddr(wbCtl.wbAddr), .writeData(wrData), .readData(bankB));
   regBank bankDI (.gclk(gclk), .reset(reset), .readEn(decEn), .readAddr(rdD),
      .writeEn(doWrite), .writeAddr(wbCtl.wbAddr), .writeData(wrData), .readData(bankD));

   always_ff @(posedge gclk) begin
      if (reset) begin
         wEn <= 1'b0;
         rdSel <= '0;
      end else begin
         wEn <= exEn;
         if (decEn) begin
            rdSel <= rdD;
         end
      end
   end

   // operand registers, regDAddr tracks which register regD holds
   always_ff @(posedge gclk) begin
      regA <= bankA;
      regB <= bankB;
      regD <= bankD;
      regDAddr <= rdSel;
   end

   // load sizer, shift the selected lane down and zero fill
   always_comb begin
      case (dwbSel)
         4'b1000: loadSized = {24'd0, dataIn[31:24]};
         4'b0100: loadSized = {24'd0, dataIn[23:16]};
         4'b0010: loadSized = {24'd0, dataIn[15:8]};
         4'b0001: loadSized = {24'd0, dataIn[7:0]};
         4'b1100: loadSized = {16'd0, dataIn[31:16]};
         4'b0011: loadSized = {16'd0, dataIn[15:0]};
         4'b1111: loadSized = dataIn;
         default: loadSized = '0;
      endcase
   end

   // an empty lane mask means no load data phase, so hold the last load
   always_ff @(posedge gclk) begin
      if (|dwbSel) begin
         loadData <= loadSized;
      end
   end

   // forward the writeback that commits at the same edge as the store
   assign fwdHit = wEn && (wbCtl.wbAddr == regDAddr) && (wbCtl.wbAddr != '0);

   always_comb begin
      if (fwdHit && wbCtl.wbSrc == WB_LOAD) begin
         storeSrc = loadData;
      end else if (fwdHit && wbCtl.wbSrc == WB_RESULT) begin
         storeSrc = result;
      end else begin
         storeSrc = regD;
      end
   end

   // store sizer, replicate across lanes
   always_comb begin
      case (accSize)
         SIZE_BYTE: storeData = {4{storeSrc[7:0]}};
         SIZE_HALF: storeData = {2{storeSrc[15:0]}};
         SIZE_WORD: storeData = storeSrc;
         default:   storeData = '0;
      endcase
   end

endmodule

/* run.sh */
#!/bin/bash
# build with Verilator and run; pass only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing -f coreDatapath.f --top-module coreDatapath_tb -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "^TEST RESULT: PASS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* tests/coreDatapath_tb.sv */
module coreDatapath_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import regfPkg::*;
   import busPkg::*;

   logic     gclk = 1'b0;
   logic     reset, exEn, decEn;
   regAddr_t rdA, rdB, rdD;
   wbCtl_t   wbCtl;
   word_t    result, regA, regB, dbgRdData, rdVal, expVal;
   pcLink_t  pcLink;
   pcLink_t  linkVal;
   memOp_t   memOp;
   dbgReq_t  dbgReq;
   logic     dbgAck;
   regAddr_t r;
   regAddr_t wrAddrs [8];
   memAddr_t loadWords [6];
   accSize_t sz;
   logic [31:0] byteAddr;
   logic [1:0] off;
   word_t    modelRegs [REG_COUNT];
   word_t    modelMem [MEM_WORDS];
   logic [15:0] lfsrState = 16'd20;
   int errors = 0;
   int testErrors = 0;
   int checkCount = 0;

   coreDatapath coreDatapath_i (.gclk(gclk), .reset(reset), .exEn(exEn), .decEn(decEn),
      .rdA(rdA), .rdB(rdB), .rdD(rdD), .wbCtl(wbCtl), .result(result), .pcLink(pcLink),
      .memOp(memOp), .dbgReq(dbgReq), .regA(regA), .regB(regB), .dbgAck(dbgAck),
      .dbgRdData(dbgRdData));

   always #10 gclk = ~gclk;

   // 16-bit Fibonacci LFSR, one step per bit
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] v;
      logic fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
         lfsrState = {lfsrState[14:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic regAddr_t randReg();
      regAddr_t a;
      a = '0;
      while (a == '0) a = regAddr_t'(randBits(5));
      return a;
   endfunction

   function automatic accSize_t pickSize(input logic [1:0] v);
      case (v)
         2'd0: return SIZE_BYTE;
         2'd1: return SIZE_HALF;
         default: return SIZE_WORD;
      endcase
   endfunction

   function automatic word_t loadLane(input accSize_t s, input logic [1:0] a, input word_t d);
      case (s)
         SIZE_BYTE: return {24'd0, d[(3 - a) * 8 +: 8]};
         SIZE_HALF: return a[1] ? {16'd0, d[15:0]} : {16'd0, d[31:16]};
         default:   return d;
      endcase
   endfunction

   task automatic check(input string name, input word_t expected, input word_t actual);
      checkCount++;
      if (expected !== actual) begin
         errors++;
         testErrors++;
         $display("FAILED %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic endTest(input string name);
      $display("test %s finished with %0d errors", name, testErrors);
      testErrors = 0;
   endtask

   task automatic writeReg(input regAddr_t a, input wbSrc_t src, input word_t d,
                           input pcLink_t link);
      @(posedge gclk);
      exEn <= 1'b1;
      @(posedge gclk);
      exEn <= 1'b0;
      wbCtl.wbAddr <= a;
      wbCtl.wbSrc <= src;
      result <= d;
      pcLink <= link;
      @(posedge gclk);
      wbCtl.wbSrc <= WB_NONE;
   endtask

   // regA, regB and regD are valid when this returns
   task automatic readRegs(input regAddr_t a, input regAddr_t b, input regAddr_t d);
      @(posedge gclk);
      decEn <= 1'b1;
      rdA <= a;
      rdB <= b;
      rdD <= d;
      @(posedge gclk);
      decEn <= 1'b0;
      @(posedge gclk);
      @(negedge gclk);
   endtask

   task automatic issueMemOp(input logic store, input accSize_t s, input logic [31:0] a);
      @(posedge gclk);
      memOp.valid <= 1'b1;
      memOp.store <= store;
      memOp.size <= s;
      memOp.addr <= a;
   endtask

   task automatic dbgStart(input logic write, input memAddr_t a, input word_t d);
      @(posedge gclk);
      dbgReq.valid <= 1'b1;
      dbgReq.write <= write;
      dbgReq.addr <= a;
      dbgReq.wdata <= d;
   endtask

   task automatic waitAck(output word_t rd);
      int cycles;
      cycles = 0;
      rd = '0;
      @(negedge gclk);
      while (!dbgAck && cycles < 50) begin
         @(negedge gclk);
         cycles++;
      end
      if (dbgAck) begin
         rd = dbgRdData;
      end else begin
         errors++;
         testErrors++;
         $display("debug access to word %0d got no ack within 50 cycles", dbgReq.addr);
      end
      @(posedge gclk);
      dbgReq.valid <= 1'b0;
   endtask

   task automatic dbgAccess(input logic write, input memAddr_t a, input word_t d,
                            output word_t rd);
      dbgStart(write, a, d);
      waitAck(rd);
   endtask

   // store from regD, optionally with a same-cycle WB_RESULT to that register
   task automatic storeOp(input accSize_t s, input logic [31:0] a, input logic fwd,
                          input regAddr_t fr, input word_t fv);
      if (fwd) begin
         @(posedge gclk);
         exEn <= 1'b1;
         @(posedge gclk);
         exEn <= 1'b0;
         wbCtl.wbAddr <= fr;
         wbCtl.wbSrc <= WB_RESULT;
         result <= fv;
         memOp.valid <= 1'b1;
         memOp.store <= 1'b1;
         memOp.size <= s;
         memOp.addr <= a;
      end else begin
         issueMemOp(1'b1, s, a);
      end
      @(posedge gclk);
      memOp.valid <= 1'b0;
      wbCtl.wbSrc <= WB_NONE;
   endtask

   // lane 3 is the lowest byte address
   task automatic modelStore(input accSize_t s, input logic [31:0] a, input word_t d);
      int n;
      int first;
      int offs;
      n = (s == SIZE_BYTE) ? 1 : ((s == SIZE_HALF) ? 2 : 4);
      first = (int'(a[1:0]) / n) * n;
      for (int lane = 0; lane < 4; lane++) begin
         offs = 3 - lane;
         if (offs >= first && offs < first + n) begin
            modelMem[a[9:2]][lane*8 +: 8] = d[(lane % n) * 8 +: 8];
         end
      end
   endtask

   // load into register dst: load op, then a WB_LOAD two cycles later
   task automatic loadOp(input accSize_t s, input logic [31:0] a, input regAddr_t dst);
      issueMemOp(1'b0, s, a);
      @(posedge gclk);
      memOp.valid <= 1'b0;
      exEn <= 1'b1;
      @(posedge gclk);
      exEn <= 1'b0;
      wbCtl.wbAddr <= dst;
      wbCtl.wbSrc <= WB_LOAD;
      @(posedge gclk);
      wbCtl.wbSrc <= WB_NONE;
   endtask

   initial begin
      reset <= 1'b1;
      exEn <= 1'b0;
      decEn <= 1'b0;
      rdA <= '0;
      rdB <= '0;
      rdD <= '0;
      wbCtl <= '{wbAddr: '0, wbSrc: WB_NONE};
      result <= '0;
      pcLink <= '0;
      memOp <= '0;
      dbgReq <= '0;
      for (int i = 0; i < MEM_WORDS; i++) modelMem[i] = '0;
      for (int i = 0; i < REG_COUNT; i++) modelRegs[i] = '0;
      repeat (5) @(posedge gclk);
      reset <= 1'b0;

      for (int i = 0; i < 8; i++) begin
         wrAddrs[i] = randReg();
         modelRegs[wrAddrs[i]] = randBits(32);
         writeReg(wrAddrs[i], WB_RESULT, modelRegs[wrAddrs[i]], '0);
      end
      for (int i = 0; i < 8; i++) begin
         readRegs(wrAddrs[i], wrAddrs[(i + 1) % 8], '0);
         check("alu_writeback_a", modelRegs[wrAddrs[i]], regA);
         check("alu_writeback_b", modelRegs[wrAddrs[(i + 1) % 8]], regB);
      end
      endTest("alu_writeback");

      writeReg('0, WB_RESULT, randBits(32), pcLink_t'(randBits(30)));
      writeReg('0, WB_LINK, randBits(32), pcLink_t'(randBits(30)));
      writeReg('0, WB_LOAD, randBits(32), pcLink_t'(randBits(30)));
      readRegs('0, '0, '0);
      check("r0_port_a", '0, regA);
      check("r0_port_b", '0, regB);
      endTest("r0_zero");

      for (int i = 0; i < 4; i++) begin
         r = randReg();
         linkVal = pcLink_t'(randBits(30));
         modelRegs[r] = {linkVal, 2'b00};
         writeReg(r, WB_LINK, randBits(32), linkVal);
         readRegs(r, r, '0);
         check("link_writeback", modelRegs[r], regA);
      end
      endTest("link_writeback");

      for (int i = 0; i < 16; i++) begin
         r = randReg();
         modelRegs[r] = randBits(32);
         writeReg(r, WB_RESULT, modelRegs[r], '0);
         readRegs(r, r, r);
         sz = pickSize(2'(randBits(2)));
         byteAddr = 32'(randBits(10));
         if (i >= 12) begin
            // forwarded value replaces the one read from regD
            modelRegs[r] = randBits(32);
            storeOp(sz, byteAddr, 1'b1, r, modelRegs[r]);
         end else begin
            storeOp(sz, byteAddr, 1'b0, '0, '0);
         end
         modelStore(sz, byteAddr, modelRegs[r]);
         dbgAccess(1'b0, byteAddr[9:2], '0, rdVal);
         check(i >= 12 ? "store_forwarded" : "store_sized", modelMem[byteAddr[9:2]], rdVal);
      end
      endTest("store_sizing");

      for (int i = 0; i < 6; i++) begin
         loadWords[i] = memAddr_t'(randBits(8));
         modelMem[loadWords[i]] = randBits(32);
         dbgAccess(1'b1, loadWords[i], modelMem[loadWords[i]], rdVal);
      end
      for (int i = 0; i < 6; i++) begin
         for (int k = 0; k < 7; k++) begin
            sz = k < 4 ? SIZE_BYTE : (k < 6 ? SIZE_HALF : SIZE_WORD);
            off = k < 4 ? 2'(k) : (k == 5 ? 2'd2 : 2'd0);
            byteAddr = {22'd0, loadWords[i], off};
            r = randReg();
            modelRegs[r] = loadLane(sz, off, modelMem[loadWords[i]]);
            loadOp(sz, byteAddr, r);
            readRegs(r, r, '0);
            check("load_sized", modelRegs[r], regA);
         end
      end
      endTest("load_sizing");

      r = randReg();
      modelRegs[r] = randBits(32);
      writeReg(r, WB_RESULT, modelRegs[r], '0);
      readRegs(r, r, r);
      expVal = randBits(32);
      dbgStart(1'b1, 8'd250, expVal);
      for (int k = 0; k < 5; k++) begin
         // debug request is presented in the first of these cycles
         if (k == 0) begin
            memOp.valid <= 1'b1;
            memOp.store <= 1'b1;
            memOp.size <= SIZE_WORD;
            memOp.addr <= 32'd400;
         end else begin
            issueMemOp(1'b1, SIZE_WORD, 32'd400 + 32'(k * 4));
         end
         modelStore(SIZE_WORD, 32'd400 + 32'(k * 4), modelRegs[r]);
      end
      @(posedge gclk);
      memOp.valid <= 1'b0;
      waitAck(rdVal);
      modelMem[250] = expVal;
      dbgAccess(1'b0, 8'd250, '0, rdVal);
      check("contention_debug_write", modelMem[250], rdVal);
      for (int k = 0; k < 5; k++) begin
         dbgAccess(1'b0, memAddr_t'(100 + k), '0, rdVal);
         check("contention_core_store", modelMem[100 + k], rdVal);
      end
      endTest("contention");

      $display("%0d checks, %0d errors", checkCount, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* verilog/coreDatapath.sv */
module coreDatapath (
   input  logic              gclk,
   input  logic              reset,
   input  logic              exEn,
   input  logic              decEn,
   input  regfPkg::regAddr_t rdA,
   input  regfPkg::regAddr_t rdB,
   input  regfPkg::regAddr_t rdD,
   input  regfPkg::wbCtl_t   wbCtl,
   input  regfPkg::word_t    result,
   input  regfPkg::pcLink_t  pcLink,
   input  busPkg::memOp_t    memOp,
   input  busPkg::dbgReq_t   dbgReq,
   output regfPkg::word_t    regA,
   output regfPkg::word_t    regB,
   output logic              dbgAck,
   output regfPkg::word_t    dbgRdData
);
   import regfPkg::*;
   import busPkg::*;

   word_t    storeData;
   word_t    rdata;
   byteSel_t dwbSel;
   accSize_t accSize;
   busReq_t  coreReq;
   busReq_t  dbgBusReq;
   busReq_t  memReq;
   logic     dbgGrant;

   regFile regFileI (
      .gclk(gclk), .reset(reset), .exEn(exEn), .decEn(decEn),
      .rdA(rdA), .rdB(rdB), .rdD(rdD),
      .wbCtl(wbCtl), .result(result), .pcLink(pcLink),
      .dwbSel(dwbSel), .dataIn(rdata), .accSize(accSize),
      .regA(regA), .regB(regB), .storeData(storeData)
   );

   lsuPort lsuPortI (
      .gclk(gclk), .reset(reset), .memOp(memOp), .storeData(storeData),
      .coreReq(coreReq), .dwbSel(dwbSel), .accSize(accSize)
   );

   debugPort debugPortI (
      .gclk(gclk), .reset(reset), .dbgReq(dbgReq), .dbgGrant(dbgGrant),
      .rdata(rdata), .dbgBusReq(dbgBusReq), .dbgAck(dbgAck),
      .dbgRdData(dbgRdData)
   );

   // core port wins every conflict
   memArbiter memArbiterI (
      .gclk(gclk), .reset(reset), .coreReq(coreReq), .dbgBusReq(dbgBusReq),
      .memReq(memReq), .dbgGrant(dbgGrant)
   );

   dataMem dataMemI (
      .gclk(gclk), .memReq(memReq), .rdata(rdata)
   );

endmodule

/* verilog/dataMem.sv */
module dataMem (
   input  logic            gclk,
   input  busPkg::busReq_t memReq,
   output regfPkg::word_t  rdata
);
   import regfPkg::*;
   import busPkg::*;

   word_t mem [MEM_WORDS];

   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   // byte masked write
   always_ff @(posedge gclk) begin
      if (memReq.valid && memReq.write) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (memReq.byteSel[lane]) begin
               mem[memReq.addr][lane*8 +: 8] <= memReq.wdata[lane*8 +: 8];
            end
         end
      end
   end

   // registered read, held between reads
   always_ff @(posedge gclk) begin
      if (memReq.valid && !memReq.write) begin
         rdata <= mem[memReq.addr];
      end
   end

endmodule

/* verilog/debugPort.sv */
module debugPort (
   input  logic            gclk,
   input  logic            reset,
   input  busPkg::dbgReq_t dbgReq,
   input  logic            dbgGrant,
   input  regfPkg::word_t  rdata,
   output busPkg::busReq_t dbgBusReq,
   output logic            dbgAck,
   output regfPkg::word_t  dbgRdData
);

   logic pending;

   // no new request while the last one is in flight or being acked
   always_comb begin
      dbgBusReq.valid = dbgReq.valid && !pending && !dbgAck;
      dbgBusReq.write = dbgReq.write;
      dbgBusReq.byteSel = '1;
      dbgBusReq.addr = dbgReq.addr;
      dbgBusReq.wdata = dbgReq.wdata;
   end

   // pending covers the cycle after issue, until the grant is known
   always_ff @(posedge gclk) begin
      if (reset) begin
         pending <= 1'b0;
         dbgAck <= 1'b0;
      end else begin
         pending <= dbgBusReq.valid;
         dbgAck <= dbgGrant;
      end
   end

   always_ff @(posedge gclk) begin
      if (dbgGrant) begin
         dbgRdData <= rdata;
      end
   end

endmodule

/* verilog/lsuPort.sv */
module lsuPort (
   input  logic             gclk,
   input  logic             reset,
   input  busPkg::memOp_t   memOp,
   input  regfPkg::word_t   storeData,
   output busPkg::busReq_t  coreReq,
   output busPkg::byteSel_t dwbSel,
   output busPkg::accSize_t accSize
);
   import busPkg::*;

   byteSel_t laneSel;

   // lane 3 holds the lowest byte address
   always_comb begin
      case (memOp.size)
         SIZE_BYTE: laneSel = byteSel_t'(4'b1000 >> memOp.addr[1:0]);
         SIZE_HALF: laneSel = memOp.addr[1] ? 4'b0011 : 4'b1100;
         SIZE_WORD: laneSel = 4'b1111;
         default:   laneSel = 4'b0000;
      endcase
   end

   always_comb begin
      coreReq.valid = memOp.valid;
      coreReq.write = memOp.store;
      coreReq.byteSel = laneSel;
      coreReq.addr = memOp.addr[MEM_ADDR_BITS+1:2];
      coreReq.wdata = storeData;
   end

   // size goes to the store sizer in the same cycle
   assign accSize = memOp.size;

   // lane mask for the returning read data, zero outside a load
   always_ff @(posedge gclk) begin
      if (reset) begin
         dwbSel <= '0;
      end else if (memOp.valid && !memOp.store) begin
         dwbSel <= laneSel;
      end else begin
         dwbSel <= '0;
      end
   end

endmodule

/* verilog/memArbiter.sv */
module memArbiter (
   input  logic            gclk,
   input  logic            reset,
   input  busPkg::busReq_t coreReq,
   input  busPkg::busReq_t dbgBusReq,
   output busPkg::busReq_t memReq,
   output logic            dbgGrant
);

   logic dbgWins;

   // core side always has priority
   assign dbgWins = dbgBusReq.valid && !coreReq.valid;

   always_comb begin
      if (dbgWins) begin
         memReq = dbgBusReq;
      end else begin
         memReq = coreReq;
      end
   end

   // grant marks the debug data phase one cycle later
   always_ff @(posedge gclk) begin
      if (reset) begin
         dbgGrant <= 1'b0;
      end else begin
         dbgGrant <= dbgWins;
      end
   end

endmodule
